// ==== compile.f ====
+incdir+rtl
rtl/axi_types_pkg.sv
rtl/mem_cmd_pkg.sv
rtl/hbmc_xfer_ctrl.sv
rtl/hbmc_sync_fifo.sv
rtl/hbmc_mem_engine.sv
rtl/hbmc_axi_top.sv
tests/tb_hbmc_axi_top.sv

// ==== rtl/axi_types_pkg.sv ====
// AXI side type definitions, imported by the control logic, the engine and the top level
`default_nettype none

`include "hbmc_defines.svh"

package axi_types_pkg;

    typedef enum logic [1:0] {
        BURST_FIXED = 2'b00,
        BURST_INCR  = 2'b01,
        BURST_WRAP  = 2'b10
    } axi_burst_t;

    typedef enum logic [1:0] {
        RESP_OKAY   = 2'b00,
        RESP_EXOKAY = 2'b01,
        RESP_SLVERR = 2'b10,
        RESP_DECERR = 2'b11
    } axi_resp_t;

    // one AW or AR request
    typedef struct packed {
        logic [`HBMC_ID_WIDTH-1:0]   id;
        logic [`HBMC_ADDR_WIDTH-1:0] addr;
        logic [7:0]                  len;
        logic [2:0]                  size;  // only 2 supported
        axi_burst_t                  burst; // all bursts run as incr
    } axi_addr_t;

    typedef struct packed {
        logic [`HBMC_DATA_WIDTH-1:0]   data;
        logic [`HBMC_DATA_WIDTH/8-1:0] strb;
    } wbeat_t;

    typedef struct packed {
        logic [`HBMC_DATA_WIDTH-1:0] data;
        logic                        last;
    } rbeat_t;

endpackage

`default_nettype wire

// ==== rtl/hbmc_axi_top.sv ====
// AXI4 slave top: wires the AXI ports to the control FSM, the two FIFOs and the engine
`timescale 1ns/10ps
`default_nettype none

`include "hbmc_defines.svh"

module hbmc_axi_top
    import axi_types_pkg::*;
    import mem_cmd_pkg::*;
(
    input  logic                          s_axi_aclk,
    input  logic                          s_axi_aresetn,

    input  logic [`HBMC_ID_WIDTH-1:0]     s_axi_awid,
    input  logic [`HBMC_ADDR_WIDTH-1:0]   s_axi_awaddr,
    input  logic [7:0]                    s_axi_awlen,
    input  logic [2:0]                    s_axi_awsize,
    input  logic [1:0]                    s_axi_awburst,
    input  logic                          s_axi_awvalid,
    output logic                          s_axi_awready,

    input  logic [`HBMC_DATA_WIDTH-1:0]   s_axi_wdata,
    input  logic [`HBMC_DATA_WIDTH/8-1:0] s_axi_wstrb,
    input  logic                          s_axi_wlast,
    input  logic                          s_axi_wvalid,
    output logic                          s_axi_wready,

    output logic [`HBMC_ID_WIDTH-1:0]     s_axi_bid,
    output logic [1:0]                    s_axi_bresp,
    output logic                          s_axi_bvalid,
    input  logic                          s_axi_bready,

    input  logic [`HBMC_ID_WIDTH-1:0]     s_axi_arid,
    input  logic [`HBMC_ADDR_WIDTH-1:0]   s_axi_araddr,
    input  logic [7:0]                    s_axi_arlen,
    input  logic [2:0]                    s_axi_arsize,
    input  logic [1:0]                    s_axi_arburst,
    input  logic                          s_axi_arvalid,
    output logic                          s_axi_arready,

    output logic [`HBMC_ID_WIDTH-1:0]     s_axi_rid,
    output logic [`HBMC_DATA_WIDTH-1:0]   s_axi_rdata,
    output logic [1:0]                    s_axi_rresp,
    output logic                          s_axi_rlast,
    output logic                          s_axi_rvalid,
    input  logic                          s_axi_rready
);
    axi_addr_t                 aw_chan;
    axi_addr_t                 ar_chan;
    logic [`HBMC_ID_WIDTH-1:0] axid;
    mem_cmd_t                  cmd;
    logic                      cmd_start;
    logic                      engine_busy;
    wbeat_t                    wf_din;
    wbeat_t                    wf_dout;
    logic                      wf_push;
    logic                      wf_pop;
    logic                      wf_full;
    logic                      wf_empty;
    rbeat_t                    rf_din;
    rbeat_t                    rf_dout;
    logic                      rf_push;
    logic                      rf_pop;
    logic                      rf_full;
    logic                      rf_empty;
    logic                      wlast_hs;
    logic                      rlast_hs;

    assign aw_chan = '{id: s_axi_awid, addr: s_axi_awaddr, len: s_axi_awlen,
                       size: s_axi_awsize, burst: axi_burst_t'(s_axi_awburst)};
    assign ar_chan = '{id: s_axi_arid, addr: s_axi_araddr, len: s_axi_arlen,
                       size: s_axi_arsize, burst: axi_burst_t'(s_axi_arburst)};

    assign wf_din       = '{data: s_axi_wdata, strb: s_axi_wstrb};
    assign s_axi_wready = ~wf_full;
    assign wf_push      = s_axi_wvalid & s_axi_wready;
    assign wlast_hs     = wf_push & s_axi_wlast;

    assign s_axi_rvalid = ~rf_empty;  // read data straight from FIFO head
    assign s_axi_rdata  = rf_dout.data;
    assign s_axi_rlast  = rf_dout.last;
    assign rf_pop       = s_axi_rvalid & s_axi_rready;
    assign rlast_hs     = rf_pop & s_axi_rlast;

    assign s_axi_bid   = axid;
    assign s_axi_rid   = axid;
    assign s_axi_bresp = RESP_OKAY;
    assign s_axi_rresp = RESP_OKAY;

    hbmc_xfer_ctrl xfer_ctrl_i (
        .s_axi_aclk    (s_axi_aclk),
        .s_axi_aresetn (s_axi_aresetn),
        .aw_chan       (aw_chan),
        .awvalid       (s_axi_awvalid),
        .ar_chan       (ar_chan),
        .arvalid       (s_axi_arvalid),
        .wlast_hs      (wlast_hs),
        .bready        (s_axi_bready),
        .rlast_hs      (rlast_hs),
        .engine_busy   (engine_busy),
        .awready       (s_axi_awready),
        .arready       (s_axi_arready),
        .bvalid        (s_axi_bvalid),
        .axid          (axid),
        .cmd           (cmd),
        .cmd_start     (cmd_start)
    );

    hbmc_sync_fifo #(.T(wbeat_t)) wr_fifo_i (
        .s_axi_aclk    (s_axi_aclk),
        .s_axi_aresetn (s_axi_aresetn),
        .push          (wf_push),
        .din           (wf_din),
        .pop           (wf_pop),
        .dout          (wf_dout),
        .full          (wf_full),
        .empty         (wf_empty)
    );

    hbmc_sync_fifo #(.T(rbeat_t)) rd_fifo_i (
        .s_axi_aclk    (s_axi_aclk),
        .s_axi_aresetn (s_axi_aresetn),
        .push          (rf_push),
        .din           (rf_din),
        .pop           (rf_pop),
        .dout          (rf_dout),
        .full          (rf_full),
        .empty         (rf_empty)
    );

    hbmc_mem_engine mem_engine_i (
        .s_axi_aclk    (s_axi_aclk),
        .s_axi_aresetn (s_axi_aresetn),
        .cmd           (cmd),
        .cmd_start     (cmd_start),
        .wf_dout       (wf_dout),
        .wf_empty      (wf_empty),
        .rf_full       (rf_full),
        .busy          (engine_busy),
        .wf_pop        (wf_pop),
        .rf_push       (rf_push),
        .rf_din        (rf_din)
    );

endmodule

`default_nettype wire

// ==== rtl/hbmc_defines.svh ====
// global widths, depths and memory size, included by the packages and RTL modules
`ifndef HBMC_DEFINES_SVH
`define HBMC_DEFINES_SVH

// AXI4 slave side
`define HBMC_DATA_WIDTH 32
`define HBMC_ADDR_WIDTH 32
`define HBMC_ID_WIDTH   2

// backing memory in bytes, 256 words of 16 bits
`define HBMC_MEM_BYTES  512

// entries per FIFO, also the longest burst (len + 1)
`define HBMC_FIFO_DEPTH 16

`endif

// ==== rtl/hbmc_mem_engine.sv ====
// memory engine: runs one command at a time on a 16-bit word array, fed by the FIFOs
`timescale 1ns/10ps
`default_nettype none

`include "hbmc_defines.svh"

module hbmc_mem_engine
    import axi_types_pkg::*;
    import mem_cmd_pkg::*;
(
    input  logic     s_axi_aclk,
    input  logic     s_axi_aresetn,
    input  mem_cmd_t cmd,
    input  logic     cmd_start,
    input  wbeat_t   wf_dout,
    input  logic     wf_empty,
    input  logic     rf_full,
    output logic     busy,
    output logic     wf_pop,
    output logic     rf_push,
    output rbeat_t   rf_din
);
    localparam int unsigned MEM_WORDS = `HBMC_MEM_BYTES / 2;

    logic [15:0]            mem [MEM_WORDS];
    logic                   wr_not_rd;
    logic [MEM_WORD_AW-1:0] word_addr;
    logic [MEM_WORD_AW-1:0] word_addr_hi;  // upper half of the beat
    logic [15:0]            words_left;
    logic                   last_beat;

    // address width equals the memory size, so +1 and +2 wrap at the end
    assign word_addr_hi = word_addr + MEM_WORD_AW'(1);
    assign last_beat    = (words_left <= 16'd2);

    assign wf_pop  = busy & wr_not_rd & ~wf_empty;
    assign rf_push = busy & ~wr_not_rd & ~rf_full;  // stall while read FIFO full
    assign rf_din  = '{data: {mem[word_addr_hi], mem[word_addr]}, last: last_beat};

    always_ff @(posedge s_axi_aclk or negedge s_axi_aresetn) begin
        if (!s_axi_aresetn) begin
            busy       <= 1'b0;
            wr_not_rd  <= 1'b0;
            word_addr  <= '0;
            words_left <= '0;
        end else if (cmd_start) begin
            busy       <= 1'b1;
            wr_not_rd  <= cmd.wr_not_rd;
            word_addr  <= cmd.word_addr;
            words_left <= cmd.word_cnt;
        end else if (wf_pop || rf_push) begin
            word_addr  <= word_addr + MEM_WORD_AW'(2);  // two words per beat
            words_left <= words_left - 16'd2;
            if (last_beat) begin
                busy <= 1'b0;
            end
        end
    end

    // halfword written only if both of its strobes are set
    always_ff @(posedge s_axi_aclk) begin
        if (wf_pop) begin
            if (&wf_dout.strb[1:0]) begin
                mem[word_addr] <= wf_dout.data[15:0];
            end
            if (&wf_dout.strb[3:2]) begin
                mem[word_addr_hi] <= wf_dout.data[31:16];
            end
        end
    end

    a_start_when_idle: assert property (@(posedge s_axi_aclk) disable iff (!s_axi_aresetn)
        cmd_start |-> !busy)
        else $error("command started while engine busy");

endmodule

`default_nettype wire

// ==== rtl/hbmc_sync_fifo.sv ====
// single clock show-ahead FIFO, payload type chosen per instance
`timescale 1ns/10ps
`default_nettype none

`include "hbmc_defines.svh"

module hbmc_sync_fifo #(
    parameter type         T     = logic,
    parameter int unsigned DEPTH = `HBMC_FIFO_DEPTH
) (
    input  logic s_axi_aclk,
    input  logic s_axi_aresetn,
    input  logic push,
    input  T     din,
    input  logic pop,
    output T     dout,
    output logic full,
    output logic empty
);
    localparam int unsigned AW = $clog2(DEPTH);

    T           mem [DEPTH];
    logic [AW:0] wr_ptr;  // extra msb tells full from empty
    logic [AW:0] rd_ptr;

    assign empty = (wr_ptr == rd_ptr);
    assign full  = (wr_ptr[AW] != rd_ptr[AW]) && (wr_ptr[AW-1:0] == rd_ptr[AW-1:0]);
    assign dout  = mem[rd_ptr[AW-1:0]];  // head entry always visible

    always_ff @(posedge s_axi_aclk or negedge s_axi_aresetn) begin
        if (!s_axi_aresetn) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
        end else begin
            if (push && !full) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (pop && !empty) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
        end
    end

    always_ff @(posedge s_axi_aclk) begin
        if (push && !full) begin
            mem[wr_ptr[AW-1:0]] <= din;
        end
    end

    a_no_overflow: assert property (@(posedge s_axi_aclk) disable iff (!s_axi_aresetn)
        push |-> !full)
        else $error("push into full FIFO");

    a_no_underflow: assert property (@(posedge s_axi_aclk) disable iff (!s_axi_aresetn)
        pop |-> !empty)
        else $error("pop from empty FIFO");

endmodule

`default_nettype wire

// ==== rtl/hbmc_xfer_ctrl.sv ====
// transaction control: picks AW or AR, builds the memory command and answers on B
`timescale 1ns/10ps
`default_nettype none

`include "hbmc_defines.svh"

module hbmc_xfer_ctrl
    import axi_types_pkg::*;
    import mem_cmd_pkg::*;
(
    input  logic                      s_axi_aclk,
    input  logic                      s_axi_aresetn,
    input  axi_addr_t                 aw_chan,
    input  logic                      awvalid,
    input  axi_addr_t                 ar_chan,
    input  logic                      arvalid,
    input  logic                      wlast_hs,
    input  logic                      bready,
    input  logic                      rlast_hs,
    input  logic                      engine_busy,
    output logic                      awready,
    output logic                      arready,
    output logic                      bvalid,
    output logic [`HBMC_ID_WIDTH-1:0] axid,
    output mem_cmd_t                  cmd,
    output logic                      cmd_start
);
    localparam int unsigned BURST_CNT_W = $clog2(`HBMC_FIFO_DEPTH + 2);
    localparam logic [`HBMC_ADDR_WIDTH-1:0] ADDR_MASK =
        `HBMC_ADDR_WIDTH'(`HBMC_MEM_BYTES - 1) & ~`HBMC_ADDR_WIDTH'(3);

    typedef enum logic [1:0] {ST_SEL, ST_INIT, ST_WAIT_DONE} xfer_state_t;
    typedef enum logic {BR_IDLE, BR_SEND} bresp_state_t;

    xfer_state_t            state;
    bresp_state_t           br_state;
    logic                   wr_addr_done;
    logic                   rd_xfer_done;
    logic [BURST_CNT_W-1:0] wr_bursts;   // complete bursts not yet answered
    logic                   wr_data_done;
    logic                   wr_cond;
    logic                   rd_cond;
    logic                   aw_hs;
    logic                   ar_hs;
    logic                   b_hs;

    // mask to memory size, align to the beat, convert to word units
    function automatic mem_cmd_t build_cmd(input axi_addr_t chan, input logic wr);
        mem_cmd_t                    c;
        logic [`HBMC_ADDR_WIDTH-1:0] byte_addr;
        byte_addr   = chan.addr & ADDR_MASK;
        c.word_addr = byte_addr[MEM_WORD_AW:1];
        c.word_cnt  = (16'(chan.len) + 16'd1) << (chan.size - 3'd1);
        c.wr_not_rd = wr;
        return c;
    endfunction

    assign aw_hs        = awvalid & awready;
    assign ar_hs        = arvalid & arready;
    assign b_hs         = bvalid & bready;
    assign wr_data_done = (wr_bursts != '0);
    assign wr_cond      = awvalid & wr_data_done;  // whole burst already buffered
    assign rd_cond      = arvalid & rd_xfer_done;
    assign bvalid       = (br_state == BR_SEND);

    always_ff @(posedge s_axi_aclk or negedge s_axi_aresetn) begin
        if (!s_axi_aresetn) begin
            state     <= ST_SEL;
            awready   <= 1'b0;
            arready   <= 1'b0;
            cmd_start <= 1'b0;
            cmd       <= '0;
            axid      <= '0;
        end else begin
            awready   <= 1'b0;
            arready   <= 1'b0;
            cmd_start <= 1'b0;
            case (state)
                ST_SEL: begin
                    // on a tie take the opposite of the last operation
                    if (wr_cond && (!rd_cond || !cmd.wr_not_rd)) begin
                        awready <= 1'b1;
                        axid    <= aw_chan.id;
                        cmd     <= build_cmd(aw_chan, 1'b1);
                        state   <= ST_INIT;
                    end else if (rd_cond) begin
                        arready <= 1'b1;
                        axid    <= ar_chan.id;
                        cmd     <= build_cmd(ar_chan, 1'b0);
                        state   <= ST_INIT;
                    end
                end
                ST_INIT: begin
                    if (!engine_busy) begin  // engine serves one command at a time
                        cmd_start <= 1'b1;
                        state     <= ST_WAIT_DONE;
                    end
                end
                ST_WAIT_DONE: begin
                    if (cmd.wr_not_rd ? !wr_addr_done : rd_xfer_done) begin
                        state <= ST_SEL;
                    end
                end
                default: state <= ST_SEL;
            endcase
        end
    end

    // write response FSM
    always_ff @(posedge s_axi_aclk or negedge s_axi_aresetn) begin
        if (!s_axi_aresetn) begin
            br_state     <= BR_IDLE;
            wr_addr_done <= 1'b0;
            wr_bursts    <= '0;
        end else begin
            wr_bursts <= wr_bursts + BURST_CNT_W'(wlast_hs) - BURST_CNT_W'(b_hs);
            if (aw_hs) begin
                wr_addr_done <= 1'b1;
            end
            case (br_state)
                BR_IDLE: begin
                    if (wr_addr_done && wr_data_done) begin
                        br_state <= BR_SEND;
                    end
                end
                BR_SEND: begin
                    if (bready) begin
                        br_state     <= BR_IDLE;
                        wr_addr_done <= 1'b0;
                    end
                end
                default: br_state <= BR_IDLE;
            endcase
        end
    end

    always_ff @(posedge s_axi_aclk or negedge s_axi_aresetn) begin
        if (!s_axi_aresetn) begin
            rd_xfer_done <= 1'b1;
        end else if (rlast_hs) begin
            rd_xfer_done <= 1'b1;
        end else if (ar_hs) begin
            rd_xfer_done <= 1'b0;  // burst open until rlast
        end
    end

    a_one_addr_ready: assert property (@(posedge s_axi_aclk) disable iff (!s_axi_aresetn)
        !(awready && arready))
        else $error("awready and arready high together");

endmodule

`default_nettype wire

// ==== rtl/mem_cmd_pkg.sv ====
// memory side command type shared by the control FSM and the memory engine
`default_nettype none

`include "hbmc_defines.svh"

package mem_cmd_pkg;

    // word address width of the 16-bit memory
    localparam int unsigned MEM_WORD_AW = $clog2(`HBMC_MEM_BYTES / 2);

    typedef struct packed {
        logic [MEM_WORD_AW-1:0] word_addr; // first 16-bit word
        logic [15:0]            word_cnt;  // words to move
        logic                   wr_not_rd;
    } mem_cmd_t;

endpackage

`default_nettype wire

// ==== tests/tb_hbmc_axi_top.sv ====
// testbench for the AXI4 memory controller top, run directed and random bursts against a model
`timescale 1ns/10ps
`default_nettype none

`include "hbmc_defines.svh"

module tb_hbmc_axi_top;
    localparam int unsigned WORDS = `HBMC_MEM_BYTES / 2;
    localparam int unsigned LIMIT = 500;  // cycles allowed per wait

    typedef logic [31:0] beat_q_t [$];

    logic                      s_axi_aclk, s_axi_aresetn;
    logic [`HBMC_ID_WIDTH-1:0] s_axi_awid, s_axi_arid, s_axi_bid, s_axi_rid;
    logic [31:0]               s_axi_awaddr, s_axi_araddr, s_axi_wdata, s_axi_rdata;
    logic [7:0]                s_axi_awlen, s_axi_arlen;
    logic [2:0]                s_axi_awsize, s_axi_arsize;
    logic [1:0]                s_axi_awburst, s_axi_arburst, s_axi_bresp, s_axi_rresp;
    logic [3:0]                s_axi_wstrb;
    logic                      s_axi_awvalid, s_axi_awready, s_axi_arvalid, s_axi_arready;
    logic                      s_axi_wlast, s_axi_wvalid, s_axi_wready;
    logic                      s_axi_bvalid, s_axi_bready;
    logic                      s_axi_rlast, s_axi_rvalid, s_axi_rready;

    logic [15:0] model [WORDS];  // expected memory contents
    integer      seed;

    hbmc_axi_top dut_i (.*);

    initial begin
        s_axi_aclk = 1'b0;
        forever #2 s_axi_aclk = ~s_axi_aclk;
    end

    task automatic stop_on_failure();
        $display("*** TEST FAILED ***");
        $fatal(1, "run stopped at first error");
    endtask

    task automatic fail_value(input string name, input logic [31:0] exp, input logic [31:0] act);
        $display("Fail %s: expected %h, actual %h", name, exp, act);
        stop_on_failure();
    endtask

    task automatic fail_text(input string what);
        $display("Error: %s", what);
        stop_on_failure();
    endtask

    task automatic check_value(input string name, input logic [31:0] exp, input logic [31:0] act);
        assert (act === exp) else fail_value(name, exp, act);
    endtask

    // byte address folded into the memory, beat aligned, in 16-bit words
    function automatic int unsigned word_index(input logic [31:0] addr, input int unsigned beat);
        logic [31:0] base;
        base = addr & (`HBMC_MEM_BYTES - 1) & ~32'd3;
        return ((base >> 1) + 2 * beat) % WORDS;
    endfunction

    task automatic model_write(input logic [31:0] addr, input beat_q_t data, input logic [3:0] strb);
        int unsigned w;
        foreach (data[i]) begin
            w = word_index(addr, i);
            if (strb[1:0] == 2'b11)
                model[w] = data[i][15:0];
            if (strb[3:2] == 2'b11)
                model[(w + 1) % WORDS] = data[i][31:16];
        end
    endtask

    task automatic predict_read(input logic [31:0] addr, input int len, output beat_q_t exp);
        int unsigned w;
        exp = {};
        for (int i = 0; i <= len; i++) begin
            w = word_index(addr, i);
            exp.push_back({model[(w + 1) % WORDS], model[w]});
        end
    endtask

    task automatic random_beats(input int n, output beat_q_t data);
        data = {};
        repeat (n) data.push_back($random(seed));
    endtask

    task automatic send_wdata(input beat_q_t data, input logic [3:0] strb);
        int t;
        foreach (data[i]) begin
            s_axi_wdata  = data[i];
            s_axi_wstrb  = strb;
            s_axi_wlast  = (i == data.size() - 1);
            s_axi_wvalid = 1'b1;
            t = 0;
            do begin
                @(negedge s_axi_aclk);
                t++;
                if (t > LIMIT)
                    fail_text("write data was not accepted in time");
            end while (!s_axi_wready);
            @(posedge s_axi_aclk);
            #1;
        end
        s_axi_wvalid = 1'b0;
        s_axi_wlast  = 1'b0;
    endtask

    task automatic send_aw(input logic [1:0] id, input logic [31:0] addr, input logic [7:0] len);
        int t;
        s_axi_awid    = id;
        s_axi_awaddr  = addr;
        s_axi_awlen   = len;
        s_axi_awvalid = 1'b1;
        t = 0;
        do begin
            @(negedge s_axi_aclk);
            t++;
            if (t > LIMIT)
                fail_text("write address was not accepted in time");
        end while (!s_axi_awready);
        @(posedge s_axi_aclk);
        #1;
        s_axi_awvalid = 1'b0;
    endtask

    task automatic take_b(input logic [1:0] id);
        int t;
        t = 0;
        do begin
            @(negedge s_axi_aclk);
            t++;
            if (t > LIMIT)
                fail_text("write response did not arrive in time");
        end while (!s_axi_bvalid);
        repeat (2) @(posedge s_axi_aclk);  // response must hold while bready is low
        #1;
        s_axi_bready = 1'b1;
        @(negedge s_axi_aclk);
        check_value("s_axi_bvalid", 1'b1, s_axi_bvalid);
        check_value("s_axi_bid", id, s_axi_bid);
        @(posedge s_axi_aclk);
        #1;
        s_axi_bready = 1'b0;
    endtask

    task automatic send_ar(input logic [1:0] id, input logic [31:0] addr, input logic [7:0] len);
        int t;
        s_axi_arid    = id;
        s_axi_araddr  = addr;
        s_axi_arlen   = len;
        s_axi_arvalid = 1'b1;
        t = 0;
        do begin
            @(negedge s_axi_aclk);
            t++;
            if (t > LIMIT)
                fail_text("read address was not accepted in time");
        end while (!s_axi_arready);
        @(posedge s_axi_aclk);
        #1;
        s_axi_arvalid = 1'b0;
    endtask

    task automatic take_r(input logic [1:0] id, input beat_q_t exp, input logic random_ready);
        int          t;
        int          n;
        logic [31:0] rnd;
        t = 0;
        n = 0;
        s_axi_rready = 1'b1;
        while (n < exp.size()) begin
            @(negedge s_axi_aclk);
            if (s_axi_rvalid && s_axi_rready) begin
                check_value("s_axi_rid", id, s_axi_rid);
                check_value("s_axi_rdata", exp[n], s_axi_rdata);
                check_value("s_axi_rlast", (n == exp.size() - 1), s_axi_rlast);
                n++;
                t = 0;
            end else begin
                t++;
                if (t > LIMIT)
                    fail_text("read data did not arrive in time");
            end
            @(posedge s_axi_aclk);
            #1;
            if (random_ready) begin
                rnd = $random(seed);
                s_axi_rready = rnd[0];
            end
        end
        s_axi_rready = 1'b0;
    endtask

    a_addr_ready_excl: assert property (@(posedge s_axi_aclk) disable iff (!s_axi_aresetn)
        !(s_axi_awready && s_axi_arready))
        else fail_text("awready and arready were high together");

    a_b_hold: assert property (@(posedge s_axi_aclk) disable iff (!s_axi_aresetn)
        s_axi_bvalid && !s_axi_bready |=> s_axi_bvalid && $stable(s_axi_bid))
        else fail_text("write response changed before bready");

    a_r_hold: assert property (@(posedge s_axi_aclk) disable iff (!s_axi_aresetn)
        s_axi_rvalid && !s_axi_rready |=> s_axi_rvalid && $stable(s_axi_rdata))
        else fail_text("read beat changed before rready");

    a_bresp_okay: assert property (@(posedge s_axi_aclk) disable iff (!s_axi_aresetn)
        s_axi_bvalid |-> s_axi_bresp == 2'b00)
        else fail_value("s_axi_bresp", 32'h0, $sampled(s_axi_bresp));

    a_rresp_okay: assert property (@(posedge s_axi_aclk) disable iff (!s_axi_aresetn)
        s_axi_rvalid |-> s_axi_rresp == 2'b00)
        else fail_value("s_axi_rresp", 32'h0, $sampled(s_axi_rresp));

    initial begin
        beat_q_t wr_data;
        beat_q_t exp;
        seed          = 32'hba4589f7;
        s_axi_aresetn = 1'b0;
        s_axi_awid    = '0;
        s_axi_awaddr  = '0;
        s_axi_awlen   = '0;
        s_axi_awsize  = 3'd2;  // 4-byte beats only
        s_axi_awburst = 2'b01;
        s_axi_awvalid = 1'b0;
        s_axi_wdata   = '0;
        s_axi_wstrb   = '0;
        s_axi_wlast   = 1'b0;
        s_axi_wvalid  = 1'b0;
        s_axi_bready  = 1'b0;
        s_axi_arid    = '0;
        s_axi_araddr  = '0;
        s_axi_arlen   = '0;
        s_axi_arsize  = 3'd2;
        s_axi_arburst = 2'b01;
        s_axi_arvalid = 1'b0;
        s_axi_rready  = 1'b0;
        repeat (3) @(posedge s_axi_aclk);
        #1;
        s_axi_aresetn = 1'b1;
        @(negedge s_axi_aclk);
        check_value("s_axi_awready", 1'b0, s_axi_awready);
        check_value("s_axi_arready", 1'b0, s_axi_arready);
        check_value("s_axi_bvalid", 1'b0, s_axi_bvalid);
        check_value("s_axi_rvalid", 1'b0, s_axi_rvalid);
        @(posedge s_axi_aclk);
        #1;

        // 4-beat burst, full strobes, read back
        random_beats(4, wr_data);
        model_write(32'h40, wr_data, 4'hf);
        send_wdata(wr_data, 4'hf);
        send_aw(2'd1, 32'h40, 8'd3);
        take_b(2'd1);
        predict_read(32'h40, 3, exp);
        send_ar(2'd2, 32'h40, 8'd3);
        take_r(2'd2, exp, 1'b0);

        // low halfword only
        random_beats(1, wr_data);
        model_write(32'h44, wr_data, 4'b0011);
        send_wdata(wr_data, 4'b0011);
        send_aw(2'd0, 32'h44, 8'd0);
        take_b(2'd0);
        predict_read(32'h44, 0, exp);
        send_ar(2'd3, 32'h44, 8'd0);
        take_r(2'd3, exp, 1'b0);

        // past the memory end plus an unaligned byte lands on the same beats
        predict_read(32'h40, 3, exp);
        send_ar(2'd1, 32'h40 + `HBMC_MEM_BYTES + 1, 8'd3);
        take_r(2'd1, exp, 1'b0);

        // full-depth burst, read back under random rready
        random_beats(16, wr_data);
        model_write(32'h100, wr_data, 4'hf);
        send_wdata(wr_data, 4'hf);
        send_aw(2'd2, 32'h100, 8'd15);
        take_b(2'd2);
        predict_read(32'h100, 15, exp);
        send_ar(2'd0, 32'h100, 8'd15);
        take_r(2'd0, exp, 1'b1);

        // write and read requested in the same cycle
        random_beats(4, wr_data);
        predict_read(32'h100, 3, exp);
        send_wdata(wr_data, 4'hf);
        model_write(32'h1c0, wr_data, 4'hf);
        fork
            begin
                send_aw(2'd3, 32'h1c0, 8'd3);
                take_b(2'd3);
            end
            begin
                send_ar(2'd1, 32'h100, 8'd3);
                take_r(2'd1, exp, 1'b0);
            end
        join
        predict_read(32'h1c0, 3, exp);
        send_ar(2'd2, 32'h1c0, 8'd3);
        take_r(2'd2, exp, 1'b0);

        $display("*** TEST PASSED ***");
        $finish;
    end

endmodule

`default_nettype wire
